/* st_ctrl_pkg.sv */
// ----------------------------------------------------------
// shared types and constants of the ST byte I/O path
// import into any module touching FIFOs or system_ctrl
// ----------------------------------------------------------
`default_nettype none

package st_ctrl_pkg;

	typedef logic [7:0]  byte_t;      // one data byte, midi or printer
	typedef logic [31:0] sys_ctrl_t;  // control word from io controller

	// usb target port on the io controller
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_RS232   = 2'd1,
		REDIR_PRINTER = 2'd2,
		REDIR_MIDI    = 2'd3
	} usb_redir_t;

	localparam int CTRL_REDIR_LSB = 26;  // system_ctrl[27:26]

	// acia data register buffer
	localparam int MIDI_FIFO_DEPTH = 16;
	// small, full flag doubles as printer busy
	localparam int PARALLEL_FIFO_DEPTH = 4;

	// channel select of an io controller read
	typedef enum logic {
		CHAN_MIDI     = 1'b0,
		CHAN_PARALLEL = 1'b1
	} io_chan_t;

endpackage

`default_nettype wire

/* st_video_pkg.sv */
// ----------------------------------------------------------
// video types and control word fields for the source mux
// ----------------------------------------------------------
`default_nettype none

package st_video_pkg;

	typedef logic [3:0] colour_t;     // 4 bit per gun, shifter and viking
	typedef logic [1:0] scanlines_t;  // 0 = off, 3 = strongest

	// scanline strength in system_ctrl[21:20]
	localparam int CTRL_SCANLINES_LSB = 20;

	// blend enable for the scaler
	localparam int CTRL_BLEND_BIT = 29;

endpackage

`default_nettype wire

/* io_fifo.sv */
// ----------------------------------------------------------
// single clock byte FIFO, show-ahead head, drops on full
// DEPTH must be a power of two, 2 or more
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module io_fifo
	import st_ctrl_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  wire        clk_32,
	input  wire        reset,
	input  wire        push,       // write strobe, one cycle
	input  wire byte_t push_data,
	input  wire        pop,        // take head, only when available
	output byte_t      head,       // oldest byte, valid while available
	output logic       full,
	output logic       available
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	byte_t         mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;     // one extra bit to tell full from empty

	logic push_ok;
	logic pop_ok;

	assign push_ok = push && !full;      // byte lost when full
	assign pop_ok  = pop && available;

	assign full      = (count == FULL_COUNT);
	assign available = (count != '0);
	assign head      = mem[rd_ptr];      // show-ahead

	// pointers wrap by themselves, DEPTH is 2^AW
	always_ff @(posedge clk_32) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none, or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk_32) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	// occupancy bounded even with pushes hammering a full buffer
	a_count_bound: assert property (@(posedge clk_32) disable iff (reset)
		count <= FULL_COUNT);

	// reader must look at available before popping
	a_no_pop_empty: assert property (@(posedge clk_32) disable iff (reset)
		pop |-> available);

endmodule

`default_nettype wire

/* st_port_writer.sv */
// ----------------------------------------------------------
// core side of the port FIFOs: flops the write strobes
// and picks the printer busy source from usb redirection
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module st_port_writer
	import st_ctrl_pkg::*;
(
	input  wire            clk_32,
	input  wire            reset,
	input  wire            midi_wr_strobe,     // acia data register write
	input  wire byte_t     midi_wr_data,
	input  wire            parallel_wr_strobe, // psg port b write
	input  wire byte_t     parallel_wr_data,
	input  wire sys_ctrl_t system_ctrl,
	input  wire            parallel_full,
	input  wire            joy_busy,           // gauntlet adapter line
	output logic           midi_push,
	output byte_t          midi_push_data,
	output logic           parallel_push,
	output byte_t          parallel_push_data,
	output logic           printer_busy
);

	usb_redir_t usb_redirection;

	assign usb_redirection = usb_redir_t'(system_ctrl[CTRL_REDIR_LSB +: $bits(usb_redir_t)]);

	// fifo is only the printer when the io controller redirects to it,
	// else busy comes from the extra joystick port
	assign printer_busy = (usb_redirection == REDIR_PRINTER) ? parallel_full : joy_busy;

	// strobes, one cycle late
	always_ff @(posedge clk_32) begin
		if (reset) begin
			midi_push     <= 1'b0;
			parallel_push <= 1'b0;
		end else begin
			midi_push     <= midi_wr_strobe;
			parallel_push <= parallel_wr_strobe;
		end
	end

	// data rides along with its strobe
	always_ff @(posedge clk_32) begin
		if (midi_wr_strobe)
			midi_push_data <= midi_wr_data;
		if (parallel_wr_strobe)
			parallel_push_data <= parallel_wr_data;
	end

	// core writes are single pulses, else a byte would be pushed twice
	a_midi_pulse: assert property (@(posedge clk_32) disable iff (reset)
		midi_push |=> !midi_push);
	a_parallel_pulse: assert property (@(posedge clk_32) disable iff (reset)
		parallel_push |=> !parallel_push);

endmodule

`default_nettype wire

/* io_ctrl_reader.sv */
// ----------------------------------------------------------
// io controller side: one read strobe pops the chosen FIFO,
// answer is a data strobe or a no-data strobe next cycle
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module io_ctrl_reader
	import st_ctrl_pkg::*;
(
	input  wire           clk_32,
	input  wire           reset,
	input  wire           rd_strobe,
	input  wire io_chan_t rd_chan,
	input  wire byte_t    midi_head,
	input  wire           midi_available,
	input  wire byte_t    parallel_head,
	input  wire           parallel_available,
	output logic          midi_pop,
	output logic          parallel_pop,
	output byte_t         host_data,
	output logic          host_strobe,   // host_data valid
	output logic          host_nodata    // channel was empty
);

	logic  sel_available;
	byte_t sel_head;

	// steer to the requested channel
	always_comb begin
		case (rd_chan)
			CHAN_PARALLEL: begin
				sel_available = parallel_available;
				sel_head      = parallel_head;
			end
			default: begin
				sel_available = midi_available;
				sel_head      = midi_head;
			end
		endcase
	end

	// pop in the strobe cycle, head already shown by the fifo
	assign midi_pop     = rd_strobe && (rd_chan == CHAN_MIDI) && midi_available;
	assign parallel_pop = rd_strobe && (rd_chan == CHAN_PARALLEL) && parallel_available;

	always_ff @(posedge clk_32) begin
		if (reset) begin
			host_strobe <= 1'b0;
			host_nodata <= 1'b0;
		end else begin
			host_strobe <= rd_strobe && sel_available;
			host_nodata <= rd_strobe && !sel_available;
		end
	end

	// byte captured only on a real pop
	always_ff @(posedge clk_32) begin
		if (rd_strobe && sel_available)
			host_data <= sel_head;
	end

	a_one_answer: assert property (@(posedge clk_32) disable iff (reset)
		!(host_strobe && host_nodata));

endmodule

`default_nettype wire

/* video_source_mux.sv */
// ----------------------------------------------------------
// shifter or viking video into the scaler, with blanking
// and scaler flags from system_ctrl, all one cycle late
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module video_source_mux
	import st_ctrl_pkg::*;
	import st_video_pkg::*;
(
	input  wire            clk_32,
	input  wire            reset,
	input  wire sys_ctrl_t system_ctrl,
	input  wire            viking_active,
	input  wire            monomode,
	input  wire            blank_n,
	input  wire            hsync_n,
	input  wire            vsync_n,
	input  wire            scandoubler_disable,  // request from io controller
	input  wire colour_t   r,
	input  wire colour_t   g,
	input  wire colour_t   b,
	input  wire colour_t   viking_r,
	input  wire colour_t   viking_g,
	input  wire colour_t   viking_b,
	input  wire            viking_hs,
	input  wire            viking_vs,
	output colour_t        vid_r,
	output colour_t        vid_g,
	output colour_t        vid_b,
	output logic           vid_hs,
	output logic           vid_vs,
	output logic           blend_en,
	output logic           scaler_bypass,
	output scanlines_t     scanlines
);

	logic show_st;

	// mono never blanks, the shifter drives its own border there
	assign show_st = blank_n | monomode;

	always_ff @(posedge clk_32) begin
		vid_r <= viking_active ? viking_r : (show_st ? r : '0);
		vid_g <= viking_active ? viking_g : (show_st ? g : '0);
		vid_b <= viking_active ? viking_b : (show_st ? b : '0);
	end

	always_ff @(posedge clk_32) begin
		if (reset) begin
			vid_hs        <= 1'b1;  // syncs idle high
			vid_vs        <= 1'b1;
			blend_en      <= 1'b0;
			scaler_bypass <= 1'b0;
			scanlines     <= '0;
		end else begin
			vid_hs        <= viking_active ? viking_hs : hsync_n;
			vid_vs        <= viking_active ? viking_vs : vsync_n;
			// no blending on hi-res sources
			blend_en      <= system_ctrl[CTRL_BLEND_BIT] & ~monomode & ~viking_active;
			scaler_bypass <= scandoubler_disable | monomode | viking_active;
			scanlines     <= system_ctrl[CTRL_SCANLINES_LSB +: $bits(scanlines_t)];
		end
	end

endmodule

`default_nettype wire

/* st_io_top.sv */
// ----------------------------------------------------------
// ST byte I/O path and video select: core writes go
// through the midi and parallel FIFOs to the io controller
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module st_io_top
	import st_ctrl_pkg::*;
	import st_video_pkg::*;
(
	input  wire            clk_32,
	input  wire            reset,
	// core writes
	input  wire            midi_wr_strobe,
	input  wire byte_t     midi_wr_data,
	input  wire            parallel_wr_strobe,
	input  wire byte_t     parallel_wr_data,
	input  wire            joy_busy,
	input  wire sys_ctrl_t system_ctrl,
	// io controller reads
	input  wire            rd_strobe,
	input  wire io_chan_t  rd_chan,
	output byte_t          host_data,
	output logic           host_strobe,
	output logic           host_nodata,
	output logic           midi_available,
	output logic           parallel_available,
	output logic           printer_busy,
	// video in
	input  wire            viking_active,
	input  wire            monomode,
	input  wire            blank_n,
	input  wire            hsync_n,
	input  wire            vsync_n,
	input  wire            scandoubler_disable,
	input  wire colour_t   r,
	input  wire colour_t   g,
	input  wire colour_t   b,
	input  wire colour_t   viking_r,
	input  wire colour_t   viking_g,
	input  wire colour_t   viking_b,
	input  wire            viking_hs,
	input  wire            viking_vs,
	// video to scaler
	output colour_t        vid_r,
	output colour_t        vid_g,
	output colour_t        vid_b,
	output logic           vid_hs,
	output logic           vid_vs,
	output logic           blend_en,
	output logic           scaler_bypass,
	output scanlines_t     scanlines
);

	logic  midi_push, parallel_push;
	byte_t midi_push_data, parallel_push_data;
	logic  midi_pop, parallel_pop;
	byte_t midi_head, parallel_head;
	logic  parallel_full;

	st_port_writer port_writer (
		.clk_32             ( clk_32             ),
		.reset              ( reset              ),
		.midi_wr_strobe     ( midi_wr_strobe     ),
		.midi_wr_data       ( midi_wr_data       ),
		.parallel_wr_strobe ( parallel_wr_strobe ),
		.parallel_wr_data   ( parallel_wr_data   ),
		.system_ctrl        ( system_ctrl        ),
		.parallel_full      ( parallel_full      ),
		.joy_busy           ( joy_busy           ),
		.midi_push          ( midi_push          ),
		.midi_push_data     ( midi_push_data     ),
		.parallel_push      ( parallel_push      ),
		.parallel_push_data ( parallel_push_data ),
		.printer_busy       ( printer_busy       )
	);

	// acia data register, midi full is not reported to the core
	io_fifo #(.DEPTH(MIDI_FIFO_DEPTH)) midi_out_fifo (
		.clk_32    ( clk_32         ),
		.reset     ( reset          ),
		.push      ( midi_push      ),
		.push_data ( midi_push_data ),
		.pop       ( midi_pop       ),
		.head      ( midi_head      ),
		.full      (                ),
		.available ( midi_available )
	);

	io_fifo #(.DEPTH(PARALLEL_FIFO_DEPTH)) parallel_out_fifo (
		.clk_32    ( clk_32             ),
		.reset     ( reset              ),
		.push      ( parallel_push      ),
		.push_data ( parallel_push_data ),
		.pop       ( parallel_pop       ),
		.head      ( parallel_head      ),
		.full      ( parallel_full      ),  // printer busy source
		.available ( parallel_available )
	);

	io_ctrl_reader ctrl_reader (
		.clk_32             ( clk_32             ),
		.reset              ( reset              ),
		.rd_strobe          ( rd_strobe          ),
		.rd_chan            ( rd_chan            ),
		.midi_head          ( midi_head          ),
		.midi_available     ( midi_available     ),
		.parallel_head      ( parallel_head      ),
		.parallel_available ( parallel_available ),
		.midi_pop           ( midi_pop           ),
		.parallel_pop       ( parallel_pop       ),
		.host_data          ( host_data          ),
		.host_strobe        ( host_strobe        ),
		.host_nodata        ( host_nodata        )
	);

	video_source_mux video_mux (
		.clk_32              ( clk_32              ),
		.reset               ( reset               ),
		.system_ctrl         ( system_ctrl         ),
		.viking_active       ( viking_active       ),
		.monomode            ( monomode            ),
		.blank_n             ( blank_n             ),
		.hsync_n             ( hsync_n             ),
		.vsync_n             ( vsync_n             ),
		.scandoubler_disable ( scandoubler_disable ),
		.r                   ( r                   ),
		.g                   ( g                   ),
		.b                   ( b                   ),
		.viking_r            ( viking_r            ),
		.viking_g            ( viking_g            ),
		.viking_b            ( viking_b            ),
		.viking_hs           ( viking_hs           ),
		.viking_vs           ( viking_vs           ),
		.vid_r               ( vid_r               ),
		.vid_g               ( vid_g               ),
		.vid_b               ( vid_b               ),
		.vid_hs              ( vid_hs              ),
		.vid_vs              ( vid_vs              ),
		.blend_en            ( blend_en            ),
		.scaler_bypass       ( scaler_bypass       ),
		.scanlines           ( scanlines           )
	);

endmodule

`default_nettype wire

/* tb_st_io_top.sv */
// ----------------------------------------------------------
// table-driven testbench for st_io_top: FIFO paths, printer
// busy select and video source mux, ends with a result line
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_st_io_top
	import st_ctrl_pkg::*;
	import st_video_pkg::*;
();

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE, OP_VID} op_t;

	// data is the write byte, or the expected byte of a read
	typedef struct packed {
		op_t       op;
		io_chan_t  chan;
		byte_t     data;
		sys_ctrl_t ctrl;
		logic      joy;
		logic      nodata;  // read should find the channel empty
		logic      busy;    // printer_busy two edges after the drive
	} step_t;

	localparam sys_ctrl_t CTRL_NONE = '0;
	localparam sys_ctrl_t CTRL_PRN  = sys_ctrl_t'(REDIR_PRINTER) << CTRL_REDIR_LSB;
	localparam sys_ctrl_t CTRL_MIDI = sys_ctrl_t'(REDIR_MIDI) << CTRL_REDIR_LSB;

	logic       clk_32, reset;
	logic       midi_wr_strobe, parallel_wr_strobe, joy_busy, rd_strobe;
	byte_t      midi_wr_data, parallel_wr_data, host_data;
	sys_ctrl_t  system_ctrl;
	io_chan_t   rd_chan;
	logic       host_strobe, host_nodata, midi_available, parallel_available, printer_busy;
	logic       viking_active, monomode, blank_n, hsync_n, vsync_n, scandoubler_disable;
	colour_t    r, g, b, viking_r, viking_g, viking_b, vid_r, vid_g, vid_b;
	logic       viking_hs, viking_vs, vid_hs, vid_vs, blend_en, scaler_bypass;
	scanlines_t scanlines;

	step_t      steps[$];
	int         errors = 0;
	logic       table_ready = 1'b0;
	integer     seed = 32'hacee_41ef;
	colour_t    exp_r, exp_g, exp_b;     // video model results
	logic       exp_hs, exp_vs, exp_blend, exp_bypass;
	scanlines_t exp_scan;

	st_io_top dut (.*);

	always #10 clk_32 = ~clk_32;  // 20 ns period

	task automatic add_step(op_t op, io_chan_t chan, byte_t data, sys_ctrl_t ctrl,
			logic joy, logic nodata, logic busy);
		step_t s;
		s.op     = op;
		s.chan   = chan;
		s.data   = data;
		s.ctrl   = ctrl;
		s.joy    = joy;
		s.nodata = nodata;
		s.busy   = busy;
		steps.push_back(s);
	endtask

	task automatic compare_value(string sig, logic [31:0] expv, logic [31:0] actv);
		if (actv !== expv) begin
			errors++;
			$display("Fail t=%0t %s expected %0h got %0h", $time, sig, expv, actv);
		end
	endtask

	// random video inputs on this edge, expected outputs from the mux rules
	task automatic drive_video();
		logic [31:0] rv;
		logic [31:0] cv;
		logic        vik;
		logic        mono;
		logic        show;
		rv   = $random(seed);
		cv   = $random(seed);
		vik  = rv[0];
		mono = rv[1];
		show = rv[2] | mono;  // shifter visible unless blanked in colour mode
		viking_active       <= vik;
		monomode            <= mono;
		blank_n             <= rv[2];
		hsync_n             <= rv[3];
		vsync_n             <= rv[4];
		scandoubler_disable <= rv[5];
		viking_hs           <= rv[6];
		viking_vs           <= rv[7];
		r                   <= rv[11:8];
		g                   <= rv[15:12];
		b                   <= rv[19:16];
		viking_r            <= rv[23:20];
		viking_g            <= rv[27:24];
		viking_b            <= rv[31:28];
		system_ctrl         <= cv;
		exp_r      = vik ? rv[23:20] : (show ? rv[11:8] : 4'h0);
		exp_g      = vik ? rv[27:24] : (show ? rv[15:12] : 4'h0);
		exp_b      = vik ? rv[31:28] : (show ? rv[19:16] : 4'h0);
		exp_hs     = vik ? rv[6] : rv[3];
		exp_vs     = vik ? rv[7] : rv[4];
		exp_blend  = cv[CTRL_BLEND_BIT] & ~mono & ~vik;
		exp_bypass = rv[5] | mono | vik;
		exp_scan   = cv[CTRL_SCANLINES_LSB +: 2];
	endtask

	task automatic build_table();
		add_step(OP_RD,   CHAN_MIDI,     8'h00, CTRL_NONE, 1'b0, 1'b1, 1'b0);  // empty read
		add_step(OP_WR,   CHAN_MIDI,     8'h11, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_MIDI,     8'h22, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_MIDI,     8'h33, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_MIDI,     8'h44, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_MIDI,     8'h55, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h11, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h22, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h33, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h44, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h55, CTRL_NONE, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h00, CTRL_NONE, 1'b0, 1'b1, 1'b0);
		// printer redirect, 4 entries fill the parallel FIFO
		add_step(OP_WR,   CHAN_PARALLEL, 8'ha1, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_PARALLEL, 8'ha2, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_PARALLEL, 8'ha3, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_PARALLEL, 8'ha4, CTRL_PRN,  1'b0, 1'b0, 1'b1);
		add_step(OP_WR,   CHAN_PARALLEL, 8'ha5, CTRL_PRN,  1'b0, 1'b0, 1'b1);  // lost
		add_step(OP_RD,   CHAN_PARALLEL, 8'ha1, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'ha2, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'ha3, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'ha4, CTRL_PRN,  1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'h00, CTRL_PRN,  1'b0, 1'b1, 1'b0);
		// midi redirect, busy tracks joy_busy even when full
		add_step(OP_WR,   CHAN_PARALLEL, 8'hb1, CTRL_MIDI, 1'b1, 1'b0, 1'b1);
		add_step(OP_WR,   CHAN_PARALLEL, 8'hb2, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_PARALLEL, 8'hb3, CTRL_MIDI, 1'b1, 1'b0, 1'b1);
		add_step(OP_WR,   CHAN_PARALLEL, 8'hb4, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_IDLE, CHAN_MIDI,     8'h00, CTRL_MIDI, 1'b1, 1'b0, 1'b1);
		add_step(OP_IDLE, CHAN_MIDI,     8'h00, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		// both FIFOs loaded, reads alternate channels
		add_step(OP_WR,   CHAN_MIDI,     8'hc1, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_WR,   CHAN_MIDI,     8'hc2, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'hb1, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'hc1, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'hb2, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'hc2, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'hb3, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_MIDI,     8'h00, CTRL_MIDI, 1'b0, 1'b1, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'hb4, CTRL_MIDI, 1'b0, 1'b0, 1'b0);
		add_step(OP_RD,   CHAN_PARALLEL, 8'h00, CTRL_MIDI, 1'b0, 1'b1, 1'b0);
		// FIFOs empty, so busy stays low whatever the random redirect
		repeat (10)
			add_step(OP_VID, CHAN_MIDI,  8'h00, CTRL_NONE, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		step_t s;
		build_table();
		table_ready = 1'b1;
		clk_32 = 1'b0;
		reset = 1'b1;
		{midi_wr_strobe, parallel_wr_strobe, rd_strobe, joy_busy} = '0;
		{midi_wr_data, parallel_wr_data, system_ctrl} = '0;
		rd_chan = CHAN_MIDI;
		{viking_active, monomode, blank_n, hsync_n, vsync_n, scandoubler_disable} = '0;
		{r, g, b, viking_r, viking_g, viking_b, viking_hs, viking_vs} = '0;
		repeat (2) @(posedge clk_32);
		reset <= 1'b0;
		@(negedge clk_32);
		compare_value("host_strobe", 32'(1'b0), 32'(host_strobe));
		compare_value("host_nodata", 32'(1'b0), 32'(host_nodata));
		compare_value("midi_available", 32'(1'b0), 32'(midi_available));
		compare_value("parallel_available", 32'(1'b0), 32'(parallel_available));
		foreach (steps[i]) begin
			s = steps[i];
			@(posedge clk_32);
			system_ctrl <= s.ctrl;
			joy_busy    <= s.joy;
			case (s.op)
				OP_WR: begin
					if (s.chan == CHAN_MIDI) begin
						midi_wr_strobe <= 1'b1;
						midi_wr_data   <= s.data;
					end else begin
						parallel_wr_strobe <= 1'b1;
						parallel_wr_data   <= s.data;
					end
				end
				OP_RD: begin
					rd_strobe <= 1'b1;
					rd_chan   <= s.chan;
				end
				OP_VID:  drive_video();
				default: ;
			endcase
			@(posedge clk_32);
			midi_wr_strobe     <= 1'b0;  // single cycle strobes
			parallel_wr_strobe <= 1'b0;
			rd_strobe          <= 1'b0;
			@(negedge clk_32);
			// answer to a read, one cycle after the strobe
			compare_value("host_strobe", 32'(s.op == OP_RD && !s.nodata), 32'(host_strobe));
			compare_value("host_nodata", 32'(s.op == OP_RD && s.nodata), 32'(host_nodata));
			if (s.op == OP_RD && !s.nodata)
				compare_value("host_data", 32'(s.data), 32'(host_data));
			if (s.op == OP_VID) begin
				compare_value("vid_r", 32'(exp_r), 32'(vid_r));
				compare_value("vid_g", 32'(exp_g), 32'(vid_g));
				compare_value("vid_b", 32'(exp_b), 32'(vid_b));
				compare_value("vid_hs", 32'(exp_hs), 32'(vid_hs));
				compare_value("vid_vs", 32'(exp_vs), 32'(vid_vs));
				compare_value("blend_en", 32'(exp_blend), 32'(blend_en));
				compare_value("scaler_bypass", 32'(exp_bypass), 32'(scaler_bypass));
				compare_value("scanlines", 32'(exp_scan), 32'(scanlines));
			end
			@(posedge clk_32);
			@(negedge clk_32);
			compare_value("printer_busy", 32'(s.busy), 32'(printer_busy));  // after the push
		end
		@(posedge clk_32);
		$display("%0d steps run, %0d errors", steps.size(), errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// 3 cycles per step used, 4 allowed, plus reset and tail
	initial begin
		longint limit;
		wait (table_ready);
		limit = longint'(steps.size()) * 4 * 20 + 500;
		#(limit);
		$display("watchdog expired, the step table did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
st_ctrl_pkg.sv
st_video_pkg.sv
io_fifo.sv
st_port_writer.sv
io_ctrl_reader.sv
video_source_mux.sv
st_io_top.sv
tb_st_io_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the st_io_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f project.f --top-module tb_st_io_top -o sim_st_io

./obj_dir/sim_st_io > sim.log 2>&1 || true
cat sim.log

# pass only when the testbench printed its pass line
grep -qx "Result: PASSED" sim.log
